// ==== build.f ====
design/bp_geom_pkg.sv
design/rv_isa_pkg.sv
design/direction_table.sv
design/target_buffer.sv
design/branch_resolver.sv
design/branch_predictor.sv
tb/tb_branch_predictor.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the branch predictor testbench with Verilator.
# The run counts as passing only if the pass line shows up in the output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f build.f \
  --top-module tb_branch_predictor \
  -Mdir obj_dir -o sim_tb \
  || { echo "verilator build failed"; exit 1; }

./obj_dir/sim_tb | tee /dev/stderr | grep -qx 'All tests passed!' \
  && echo "simulation result: PASS" \
  || { echo "simulation result: FAIL"; exit 1; }

exit 0

// ==== tb/tb_branch_predictor.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_branch_predictor
  import rv_isa_pkg::*;
  import bp_geom_pkg::*;
();

  localparam int    NUM_TESTS = 6;
  localparam int    CYCLE     = 40;
  localparam xlen_t PC_A      = 32'h0000_2a10;  // trained in test 3, aliased in test 6
  localparam xlen_t TGT_A     = 32'h0000_3300;

  logic    clk;
  logic    rst;
  xlen_t   pc_d;
  opcode_t op_d;
  xlen_t   pc_e;
  logic    branch_e;
  logic    taken_e;
  xlen_t   target_e;
  logic    upd_req;
  logic    pred_taken_d;
  xlen_t   pred_pc_d;
  logic    flush_d;
  logic    flush_e;
  xlen_t   redirect_pc;
  logic    upd_ack;

  // reference copy of both tables
  int       dir_model       [DIR_ENTRIES];
  logic     btb_valid_model [BTB_ENTRIES];
  btb_tag_t btb_tag_model   [BTB_ENTRIES];
  xlen_t    btb_tgt_model   [BTB_ENTRIES];

  logic  exp_taken_d;
  xlen_t exp_pc_d;
  logic  exp_pred_e;
  logic  exp_mispredict;
  xlen_t exp_redirect;
  int    errors;
  int    errors_at_start;
  int    tests_run;

  branch_predictor i_branch_predictor (
    .clk(clk), .rst(rst), .pc_d(pc_d), .op_d(op_d),
    .pc_e(pc_e), .branch_e(branch_e), .taken_e(taken_e), .target_e(target_e),
    .upd_req(upd_req), .pred_taken_d(pred_taken_d), .pred_pc_d(pred_pc_d),
    .flush_d(flush_d), .flush_e(flush_e), .redirect_pc(redirect_pc), .upd_ack(upd_ack)
  );

  always #(CYCLE / 2) clk = ~clk;

  // counter index pc[9:2], buffer index pc[7:2], tag pc[15:8]
  always_comb begin
    exp_taken_d = (op_d == OP_BRANCH) && (dir_model[pc_d[9:2]] >= 2)
                  && btb_valid_model[pc_d[7:2]] && (btb_tag_model[pc_d[7:2]] == pc_d[15:8]);
    exp_pc_d = exp_taken_d ? btb_tgt_model[pc_d[7:2]] : pc_d + 32'd4;
    exp_pred_e = branch_e && (dir_model[pc_e[9:2]] >= 2)
                 && btb_valid_model[pc_e[7:2]] && (btb_tag_model[pc_e[7:2]] == pc_e[15:8]);
    exp_mispredict = exp_pred_e != (branch_e && taken_e);
    exp_redirect = (branch_e && taken_e) ? target_e : pc_e + 32'd4;
  end

  task automatic log_error(input string msg);
    $display("FAIL %0t: %s", $time, msg);
    errors++;
  endtask

  assert property (@(negedge clk) disable iff (rst)
      pred_taken_d == exp_taken_d && pred_pc_d == exp_pc_d)
    else log_error($sformatf("decode pc %h predicted %b/%h", pc_d, pred_taken_d, pred_pc_d));

  assert property (@(negedge clk) disable iff (rst)
      $rose(upd_req) |-> flush_d == exp_mispredict && flush_e == exp_mispredict
                         && redirect_pc == exp_redirect)
    else log_error($sformatf("first request cycle flush %b redirect %h", flush_d, redirect_pc));

  assert property (@(negedge clk) disable iff (rst)
      !$rose(upd_req) |-> !flush_d && !flush_e)
    else log_error("flush outside the first request cycle");

  // ack rises exactly 2 cycles after req, falls 1 cycle after req drops
  assert property (@(negedge clk) disable iff (rst)
      $rose(upd_ack) == ($past(upd_req, 2) && !$past(upd_req, 3)))
    else log_error("upd_ack rise timing");

  assert property (@(negedge clk) disable iff (rst)
      $fell(upd_ack) == ($past(upd_req, 2) && !$past(upd_req)))
    else log_error("upd_ack fall timing");

  assert property (@(negedge clk) disable iff (rst)
      ($past(upd_ack) && $past(upd_req)) |-> upd_ack)
    else log_error("upd_ack dropped while upd_req held");

  task automatic train_model(input xlen_t pc, input logic taken, input xlen_t tgt);
    if (taken && dir_model[pc[9:2]] < 3) begin
      dir_model[pc[9:2]] = dir_model[pc[9:2]] + 1;
    end else if (!taken && dir_model[pc[9:2]] > 0) begin
      dir_model[pc[9:2]] = dir_model[pc[9:2]] - 1;
    end
    if (taken) begin  // only taken branches get a buffer entry
      btb_valid_model[pc[7:2]] = 1'b1;
      btb_tag_model[pc[7:2]]   = pc[15:8];
      btb_tgt_model[pc[7:2]]   = tgt;
    end
  endtask

  task automatic lookup(input xlen_t pc, input opcode_t op);
    @(posedge clk);
    #2;
    pc_d = pc;
    op_d = op;
  endtask

  task automatic expect_pred(input logic taken, input xlen_t npc, input string what);
    @(negedge clk);
    assert (pred_taken_d == taken && pred_pc_d == npc)
      else log_error($sformatf("%s: got %b/%h, expected %b/%h",
                               what, pred_taken_d, pred_pc_d, taken, npc));
  endtask

  // full four-phase handshake with flush sampled in the first request cycle
  task automatic resolve(input xlen_t pc, input logic taken, input xlen_t tgt, input int hold,
                         output logic flushed, output xlen_t redir);
    @(posedge clk);
    #2;
    pc_e     = pc;
    branch_e = 1'b1;
    taken_e  = taken;
    target_e = tgt;
    upd_req  = 1'b1;
    @(negedge clk);
    flushed = flush_d && flush_e;
    redir   = redirect_pc;
    while (!upd_ack) begin
      @(posedge clk);
      #2;
    end
    train_model(pc, taken, tgt);
    repeat (hold) begin
      @(posedge clk);
      #2;
    end
    upd_req = 1'b0;
    while (upd_ack) begin
      @(posedge clk);
      #2;
    end
    branch_e = 1'b0;
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (errors == errors_at_start) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      $display("test %0d %s: %0d errors", tests_run, name, errors - errors_at_start);
    end
  endtask

  task automatic reset_lookups();
    xlen_t pc;
    errors_at_start = errors;
    repeat (4) begin
      pc = $urandom & 32'h0000_fffc;
      lookup(pc, OP_BRANCH);
      expect_pred(1'b0, pc + 32'd4, "cold lookup");
      assert (!flush_d && !flush_e && !upd_ack)
        else log_error("flush or upd_ack high after reset");
    end
    report_test("reset lookups");
  endtask

  task automatic handshake_hold();
    logic  fl;
    xlen_t rd;
    errors_at_start = errors;
    resolve(32'h0000_1040, 1'b0, 32'h0, 4, fl, rd);  // req held 4 extra cycles
    assert (!fl) else log_error("flush on a correct not-taken resolution");
    report_test("handshake hold");
  endtask

  task automatic train_two_taken();
    logic  fl;
    xlen_t rd;
    errors_at_start = errors;
    resolve(PC_A, 1'b1, TGT_A, 0, fl, rd);
    lookup(PC_A, OP_BRANCH);
    expect_pred(1'b0, PC_A + 32'd4, "one taken resolution");
    resolve(PC_A, 1'b1, TGT_A, 0, fl, rd);
    lookup(PC_A, OP_BRANCH);
    expect_pred(1'b1, TGT_A, "two taken resolutions");
    lookup(PC_A, 7'b0110011);  // register alu op
    expect_pred(1'b0, PC_A + 32'd4, "non-branch opcode");
    lookup(PC_A, 7'b1101111);  // jal
    expect_pred(1'b0, PC_A + 32'd4, "jump opcode");
    report_test("training");
  endtask

  task automatic mispredict_flush();
    xlen_t pc;
    xlen_t tgt;
    logic  fl;
    xlen_t rd;
    errors_at_start = errors;
    pc  = 32'h0000_4c20;
    tgt = 32'h0000_4000;
    resolve(pc, 1'b1, tgt, 0, fl, rd);
    assert (fl && rd == tgt) else log_error("missed taken, no flush to target");
    resolve(pc, 1'b1, tgt, 0, fl, rd);
    assert (fl) else log_error("weakly not taken resolved taken, no flush");
    resolve(pc, 1'b1, tgt, 0, fl, rd);
    assert (!fl) else log_error("correct taken prediction flushed");
    resolve(pc, 1'b0, tgt, 0, fl, rd);
    assert (fl && rd == pc + 32'd4) else log_error("wrong taken, no flush to pc+4");
    resolve(pc, 1'b0, tgt, 0, fl, rd);
    resolve(pc, 1'b0, tgt, 0, fl, rd);
    assert (!fl) else log_error("correct not-taken prediction flushed");
    report_test("mispredict");
  endtask

  task automatic counter_hysteresis();
    xlen_t pc;
    xlen_t tgt;
    logic  fl;
    xlen_t rd;
    errors_at_start = errors;
    pc  = 32'h0000_8e7c;
    tgt = 32'h0000_9000;
    repeat (3) resolve(pc, 1'b1, tgt, 0, fl, rd);  // up to strongly taken
    resolve(pc, 1'b0, tgt, 0, fl, rd);
    lookup(pc, OP_BRANCH);
    expect_pred(1'b1, tgt, "one not-taken from strong");
    resolve(pc, 1'b0, tgt, 0, fl, rd);
    lookup(pc, OP_BRANCH);
    expect_pred(1'b0, pc + 32'd4, "two not-taken from strong");
    report_test("hysteresis");
  endtask

  task automatic tag_alias();
    logic [5:0] flip;
    xlen_t      pc;
    logic       fl;
    xlen_t      rd;
    errors_at_start = errors;
    repeat (3) begin
      flip = 6'(($urandom % 63) + 1);  // nonzero so pc[15:10] differs
      pc   = {16'h0, PC_A[15:10] ^ flip, PC_A[9:0]};
      lookup(pc, OP_BRANCH);
      expect_pred(1'b0, pc + 32'd4, "aliased tag");
    end
    lookup(PC_A, OP_BRANCH);
    expect_pred(1'b1, TGT_A, "owner of the entry");
    resolve(pc, 1'b0, 32'h0, 0, fl, rd);  // execute recheck misses the buffer too
    assert (!fl) else log_error("flush on an aliased not-taken branch");
    report_test("aliasing");
  endtask

  initial begin
    #((NUM_TESTS * 40 + 5) * CYCLE);
    $display("timeout: tests did not finish in time");
    $display("Test failures found");
    $finish;
  end

  initial begin
    void'($urandom(20));
    clk       = 1'b0;
    rst       = 1'b1;
    pc_d      = '0;
    op_d      = '0;
    pc_e      = '0;
    branch_e  = 1'b0;
    taken_e   = 1'b0;
    target_e  = '0;
    upd_req   = 1'b0;
    errors    = 0;
    tests_run = 0;
    for (int i = 0; i < DIR_ENTRIES; i++) dir_model[i] = 0;  // strongly not taken
    for (int i = 0; i < BTB_ENTRIES; i++) begin
      btb_valid_model[i] = 1'b0;
      btb_tag_model[i]   = '0;
      btb_tgt_model[i]   = '0;
    end
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;
    reset_lookups();
    handshake_hold();
    train_two_taken();
    mispredict_flush();
    counter_hysteresis();
    tag_alias();
    repeat (2) @(posedge clk);
    $display("tests run: %0d, errors: %0d", tests_run, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== design/branch_predictor.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_predictor
  import rv_isa_pkg::*;
  import bp_geom_pkg::*;
(
  input  wire     clk,
  input  wire     rst,
  // decode
  input  xlen_t   pc_d,
  input  opcode_t op_d,
  // execute
  input  xlen_t   pc_e,
  input  wire     branch_e,
  input  wire     taken_e,
  input  xlen_t   target_e,
  input  wire     upd_req,
  // outputs
  output logic    pred_taken_d,
  output xlen_t   pred_pc_d,
  output logic    flush_d,
  output logic    flush_e,
  output xlen_t   redirect_pc,
  output logic    upd_ack
);

  ctr_t     ctr_d;
  ctr_t     ctr_e;
  logic     dir_we;
  dir_idx_t dir_idx_w;
  ctr_t     dir_wdata;

  logic     hit_d;
  xlen_t    tgt_d;
  logic     hit_e;
  logic     btb_we;
  xlen_t    btb_pc_w;
  xlen_t    btb_tgt_w;

  direction_table i_dir (
    .clk     (clk),
    .rst     (rst),
    .rd_pc_d (pc_d),
    .rd_pc_e (pc_e),
    .we      (dir_we),
    .idx_w   (dir_idx_w),
    .wdata   (dir_wdata),
    .ctr_d   (ctr_d),
    .ctr_e   (ctr_e)
  );

  target_buffer i_btb (
    .clk     (clk),
    .rst     (rst),
    .rd_pc_d (pc_d),
    .rd_pc_e (pc_e),
    .we      (btb_we),
    .pc_w    (btb_pc_w),
    .tgt_w   (btb_tgt_w),
    .hit_d   (hit_d),
    .tgt_d   (tgt_d),
    .hit_e   (hit_e)
  );

  branch_resolver i_res (
    .clk          (clk),
    .rst          (rst),
    .op_d         (op_d),
    .pc_d         (pc_d),
    .ctr_d        (ctr_d),
    .hit_d        (hit_d),
    .tgt_d        (tgt_d),
    .pc_e         (pc_e),
    .ctr_e        (ctr_e),
    .hit_e        (hit_e),
    .branch_e     (branch_e),
    .taken_e      (taken_e),
    .target_e     (target_e),
    .upd_req      (upd_req),
    .pred_taken_d (pred_taken_d),
    .pred_pc_d    (pred_pc_d),
    .flush_d      (flush_d),
    .flush_e      (flush_e),
    .redirect_pc  (redirect_pc),
    .upd_ack      (upd_ack),
    .dir_we       (dir_we),
    .dir_idx_w    (dir_idx_w),
    .dir_wdata    (dir_wdata),
    .btb_we       (btb_we),
    .btb_pc_w     (btb_pc_w),
    .btb_tgt_w    (btb_tgt_w)
  );

endmodule

`default_nettype wire

// ==== design/branch_resolver.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_resolver
  import rv_isa_pkg::*;
  import bp_geom_pkg::*;
(
  input  wire      clk,
  input  wire      rst,
  // decode side
  input  opcode_t  op_d,
  input  xlen_t    pc_d,
  input  ctr_t     ctr_d,
  input  wire      hit_d,
  input  xlen_t    tgt_d,
  // execute side
  input  xlen_t    pc_e,
  input  ctr_t     ctr_e,
  input  wire      hit_e,
  input  wire      branch_e,
  input  wire      taken_e,
  input  xlen_t    target_e,
  input  wire      upd_req,
  // pipeline control
  output logic     pred_taken_d,
  output xlen_t    pred_pc_d,
  output logic     flush_d,
  output logic     flush_e,
  output xlen_t    redirect_pc,
  output logic     upd_ack,
  // table writes
  output logic     dir_we,
  output dir_idx_t dir_idx_w,
  output ctr_t     dir_wdata,
  output logic     btb_we,
  output xlen_t    btb_pc_w,
  output xlen_t    btb_tgt_w
);

  upd_state_t state;
  upd_state_t state_next;

  logic pred_e;       // prediction recomputed at pc_e
  logic actual_e;
  logic mispredict;

  // decode prediction, needs counter and a btb hit
  assign pred_taken_d = (op_d == OP_BRANCH) && ctr_d[CTR_MSB] && hit_d;
  assign pred_pc_d    = pred_taken_d ? tgt_d : pc_d + INST_BYTES;

  // execute check
  assign pred_e     = branch_e && ctr_e[CTR_MSB] && hit_e;
  assign actual_e   = branch_e && taken_e;
  assign mispredict = pred_e != actual_e;

  // only meaningful in the first request cycle
  assign flush_d     = (state == UPD_IDLE) && upd_req && mispredict;
  assign flush_e     = flush_d;
  assign redirect_pc = actual_e ? target_e : pc_e + INST_BYTES;

  always_comb begin
    state_next = state;
    case (state)
      UPD_IDLE:  if (upd_req) state_next = UPD_WRITE;
      UPD_WRITE: state_next = UPD_HOLD;   // single write cycle
      UPD_HOLD:  if (!upd_req) state_next = UPD_IDLE;
      default:   state_next = UPD_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= UPD_IDLE;
      upd_ack <= 1'b0;
    end else begin
      state   <= state_next;
      upd_ack <= (state_next == UPD_HOLD);  // high for all of HOLD
    end
  end

  // saturating counter step
  always_comb begin
    case (ctr_e)
      CTR_SNT: dir_wdata = taken_e ? CTR_WNT : CTR_SNT;
      CTR_WNT: dir_wdata = taken_e ? CTR_WT  : CTR_SNT;
      CTR_WT:  dir_wdata = taken_e ? CTR_ST  : CTR_WNT;
      default: dir_wdata = taken_e ? CTR_ST  : CTR_WT;
    endcase
  end

  // requester holds pc_e and outcome stable through WRITE
  assign dir_we    = (state == UPD_WRITE) && branch_e;
  assign dir_idx_w = pc_e[IDX_LSB +: DIR_IDX_W];

  assign btb_we    = (state == UPD_WRITE) && actual_e;  // install taken only
  assign btb_pc_w  = pc_e;
  assign btb_tgt_w = target_e;

endmodule

`default_nettype wire

// ==== design/target_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module target_buffer
  import rv_isa_pkg::*;
  import bp_geom_pkg::*;
(
  input  wire   clk,
  input  wire   rst,
  input  xlen_t rd_pc_d,
  input  xlen_t rd_pc_e,
  input  wire   we,
  input  xlen_t pc_w,     // branch being installed
  input  xlen_t tgt_w,
  output logic  hit_d,
  output xlen_t tgt_d,
  output logic  hit_e
);

  logic     valid_mem [BTB_ENTRIES];
  btb_tag_t tag_mem   [BTB_ENTRIES];
  xlen_t    tgt_mem   [BTB_ENTRIES];

  btb_idx_t idx_d;
  btb_idx_t idx_e;
  btb_idx_t idx_w;
  btb_tag_t tag_d;
  btb_tag_t tag_e;
  btb_tag_t tag_w;

  // index from pc[7:2], tag from pc[15:8]
  assign idx_d = rd_pc_d[IDX_LSB +: BTB_IDX_W];
  assign idx_e = rd_pc_e[IDX_LSB +: BTB_IDX_W];
  assign idx_w = pc_w[IDX_LSB +: BTB_IDX_W];

  assign tag_d = rd_pc_d[BTB_TAG_LSB +: BTB_TAG_W];
  assign tag_e = rd_pc_e[BTB_TAG_LSB +: BTB_TAG_W];
  assign tag_w = pc_w[BTB_TAG_LSB +: BTB_TAG_W];

  // decode port returns a target, execute port only needs the hit
  assign hit_d = valid_mem[idx_d] && (tag_mem[idx_d] == tag_d);
  assign tgt_d = tgt_mem[idx_d];
  assign hit_e = valid_mem[idx_e] && (tag_mem[idx_e] == tag_e);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < BTB_ENTRIES; i++) begin
        valid_mem[i] <= 1'b0;
      end
    end else if (we) begin
      valid_mem[idx_w] <= 1'b1;
    end
  end

  // tag and target ride along with the valid bit
  always_ff @(posedge clk) begin
    if (we) begin
      tag_mem[idx_w] <= tag_w;  // replaces any alias
      tgt_mem[idx_w] <= tgt_w;
    end
  end

endmodule

`default_nettype wire

// ==== design/direction_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module direction_table
  import rv_isa_pkg::*;
  import bp_geom_pkg::*;
(
  input  wire      clk,
  input  wire      rst,
  input  xlen_t    rd_pc_d,   // decode lookup
  input  xlen_t    rd_pc_e,   // execute recheck
  input  wire      we,
  input  dir_idx_t idx_w,
  input  ctr_t     wdata,
  output ctr_t     ctr_d,
  output ctr_t     ctr_e
);

  ctr_t     ctr_mem [DIR_ENTRIES];

  dir_idx_t idx_d;
  dir_idx_t idx_e;

  assign idx_d = rd_pc_d[IDX_LSB +: DIR_IDX_W];
  assign idx_e = rd_pc_e[IDX_LSB +: DIR_IDX_W];

  // both read ports are combinational
  assign ctr_d = ctr_mem[idx_d];
  assign ctr_e = ctr_mem[idx_e];

  // whole array back to strongly not taken in one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DIR_ENTRIES; i++) begin
        ctr_mem[i] <= CTR_SNT;
      end
    end else if (we) begin
      ctr_mem[idx_w] <= wdata;  // new value comes from resolver
    end
  end

endmodule

`default_nettype wire

// ==== design/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

  localparam int XLEN     = 32;
  localparam int OPCODE_W = 7;

  // pc or branch target
  typedef logic [XLEN-1:0] xlen_t;

  // major opcode, inst[6:0]
  typedef logic [OPCODE_W-1:0] opcode_t;

  // fall-through step, no compressed instructions
  localparam xlen_t INST_BYTES = 32'd4;

  // conditional branches: beq bne blt bge bltu bgeu
  localparam opcode_t OP_BRANCH = 7'b1100011;

endpackage

`default_nettype wire

// ==== design/bp_geom_pkg.sv ====
`default_nettype none

package bp_geom_pkg;

  // table sizes
  localparam int DIR_ENTRIES = 256;
  localparam int BTB_ENTRIES = 64;

  localparam int IDX_LSB     = 2;                     // word aligned pc
  localparam int DIR_IDX_W   = $clog2(DIR_ENTRIES);   // pc[9:2]
  localparam int BTB_IDX_W   = $clog2(BTB_ENTRIES);   // pc[7:2]
  localparam int BTB_TAG_W   = 8;
  localparam int BTB_TAG_LSB = IDX_LSB + BTB_IDX_W;   // pc[15:8]

  typedef logic [DIR_IDX_W-1:0] dir_idx_t;
  typedef logic [BTB_IDX_W-1:0] btb_idx_t;
  typedef logic [BTB_TAG_W-1:0] btb_tag_t;

  // 2-bit saturating counter
  typedef logic [1:0] ctr_t;

  localparam int   CTR_MSB = 1;                       // set means predict taken
  localparam ctr_t CTR_SNT = 2'b00;                   // reset value
  localparam ctr_t CTR_WNT = 2'b01;
  localparam ctr_t CTR_WT  = 2'b10;
  localparam ctr_t CTR_ST  = 2'b11;

  // training handshake FSM
  typedef enum logic [1:0] {
    UPD_IDLE,
    UPD_WRITE,
    UPD_HOLD
  } upd_state_t;

endpackage

`default_nettype wire
